// File: all.f
rtl/aluPkg.sv
rtl/aluAdder.sv
rtl/aluShifter.sv
rtl/aluCore.sv
rtl/ccrReg.sv
rtl/aluTop.sv
dv/aluTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the ALU testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module aluTb -f all.f -o aluSim \
	&& ./obj_dir/aluSim 2>&1 | tee sim.log
test -s sim.log || { echo "Build or run produced no log"; exit 1; }
grep -q "Test failures found" sim.log && { echo "Simulation FAILED"; exit 1; } \
	|| { echo "Simulation PASSED"; exit 0; }

// File: dv/aluTb.sv
/*
 ALU testbench
 Drives random and directed ops into aluTop, keeps a reference model of
 aluOut and the CCR, and checks the DUT every cycle with assertions
*/
`timescale 1ns/1ps
`default_nettype none

module aluTb;

	localparam int W = aluPkg::dataW;
	localparam int numOps = 17;	// Every aluOp_t code
	localparam int opsPerCase = 40;	// Random ops per op and size
	localparam int directedCycles = 60;	// Reset, sticky Z, load, hold, drain
	// One CCR load in front of each op/size block
	localparam int stimCycles = numOps * 2 * (opsPerCase + 1) + directedCycles;
	localparam int cycleLimit = 2 * stimCycles;

	logic clk = 1'b0;
	logic arstN;
	logic opValid;
	aluPkg::aluOp_t op;
	logic isByte;
	logic [W-1:0] srcOp;
	logic [W-1:0] dstOp;
	logic ccrLoad;
	aluPkg::ccr_t ccrIn;
	logic [W-1:0] aluOut;
	aluPkg::ccr_t ccr;
	logic ze;

	logic [W-1:0] mdlOut, expOut;	// Model state and its copy delayed to DUT timing
	aluPkg::ccr_t mdlCcr, expCcr;
	logic [31:0] lcgState = 32'hb908_9206;
	int cycles;

	always #10 clk = ~clk;	// 20 ns period

	aluTop i_aluTop (
		.clk, .arstN, .opValid, .op, .isByte, .srcOp, .dstOp,
		.ccrLoad, .ccrIn, .aluOut, .ccr, .ze
	);

	task automatic failValue(input string name, input logic [W-1:0] expVal,
			input logic [W-1:0] actVal);
		$display("[FAIL] %s expected 0x%h actual 0x%h", name, expVal, actVal);
		$display("Test failures found");
		$fatal(1, "%s mismatch", name);
	endtask

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "run aborted");
	endtask

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Operands biased toward carry, overflow and zero corners
	function automatic logic [W-1:0] randWord();
		logic [31:0] r;
		r = nextRand();
		case (r[31:29])
			3'd0: return '0;
			3'd1: return '1;
			3'd2: return r[28] ? 16'h8000 : 16'h7fff;	// Word sign edge
			3'd3: return r[28] ? 16'h0080 : 16'h007f;	// Byte sign edge
			default: return r[23:8];
		endcase
	endfunction

	function automatic aluPkg::ccr_t randCcr();
		logic [31:0] r;
		r = nextRand();
		return aluPkg::ccr_t'(r[20:16]);
	endfunction

	function automatic int signedAt(input int v, input int lim);
		return (v >= lim / 2) ? v - lim : v;
	endfunction

	// Low size bits placed in a word with byte results sign-extended
	function automatic logic [W-1:0] sizeResult(input int v, input logic b);
		logic [W-1:0] w;
		w = W'(v);
		return b ? {{(W-8){w[7]}}, w[7:0]} : w;
	endfunction

	// Reference model of one operation
	function automatic void refAlu(input aluPkg::aluOp_t o, input logic b,
			input logic [W-1:0] src, input logic [W-1:0] dst, input aluPkg::ccr_t old,
			output logic [W-1:0] res, output aluPkg::ccr_t f);
		int lim, s, d, cin, t, sres;
		logic keepX, sticky, fillB, right;
		logic [7:0] lo8;
		lim = b ? 256 : (1 << W);
		s = b ? int'(src[7:0]) : int'(src);
		d = b ? int'(dst[7:0]) : int'(dst);
		cin = (o == aluPkg::opAddx || o == aluPkg::opSubx) ? int'(old.x) : 0;
		f = old;
		f.v = 1'b0;
		f.c = 1'b0;
		keepX = 1'b1;
		sticky = 1'b0;
		case (o)
			aluPkg::opAnd, aluPkg::opOr, aluPkg::opEor: begin
				res = (o == aluPkg::opAnd) ? (dst & src) :
				      (o == aluPkg::opOr) ? (dst | src) : (dst ^ src);
				if (b) res[W-1:8] = dst[W-1:8];	// Byte op leaves upper dst byte
			end
			aluPkg::opExt: res = {{(W-8){src[7]}}, src[7:0]};
			aluPkg::opAdd, aluPkg::opAddx, aluPkg::opSub, aluPkg::opSubx: begin
				if (o == aluPkg::opAdd || o == aluPkg::opAddx) begin
					t = d + s + cin;
					f.c = (t >= lim);
					sres = signedAt(d, lim) + signedAt(s, lim) + cin;
				end else begin
					t = d - s - cin;
					f.c = (t < 0);	// Borrow
					sres = signedAt(d, lim) - signedAt(s, lim) - cin;
				end
				f.v = (sres >= lim / 2) || (sres < -(lim / 2));	// Outside signed range
				res = sizeResult((t + lim) % lim, b);
				keepX = 1'b0;
				sticky = (o == aluPkg::opAddx || o == aluPkg::opSubx);
			end
			aluPkg::opNot: res = sizeResult(lim - 1 - s, b);	// C and V stay clear
			default: begin
				right = (o == aluPkg::opLsr || o == aluPkg::opAsr ||
				         o == aluPkg::opRor || o == aluPkg::opRoxr);
				case (o)
					aluPkg::opAsr, aluPkg::opRol: fillB = b ? src[7] : src[W-1];
					aluPkg::opRor: fillB = src[0];
					aluPkg::opRoxl, aluPkg::opRoxr: fillB = old.x;
					default: fillB = 1'b0;
				endcase
				if (b) begin
					if (right) begin
						f.c = src[0];
						lo8 = {fillB, src[7:1]};
					end else begin
						f.c = src[7];
						lo8 = {src[6:0], fillB};
					end
					res = {src[W-1:8], lo8};
				end else if (right) begin
					f.c = src[0];
					res = {fillB, src[W-1:1]};
				end else begin
					f.c = src[W-1];
					res = {src[W-2:0], fillB};
				end
				if (o == aluPkg::opAsl) begin
					f.v = b ? (src[7] ^ src[6]) : (src[W-1] ^ src[W-2]);
				end
				keepX = (o == aluPkg::opRol || o == aluPkg::opRor);
			end
		endcase
		if (!keepX) f.x = f.c;
		f.n = b ? res[7] : res[W-1];
		f.z = b ? (res[7:0] == 8'h00) : (res == '0);
		if (sticky) f.z = f.z & old.z;	// Chain stays zero only if all parts are
	endfunction

	// One clock of stimulus with the model advanced in step
	task automatic applyCycle(input logic valid, input logic load, input aluPkg::aluOp_t o,
			input logic b, input logic [W-1:0] s, input logic [W-1:0] d,
			input aluPkg::ccr_t ldVal);
		logic [W-1:0] r;
		aluPkg::ccr_t f;
		@(posedge clk);
		refAlu(o, b, s, d, mdlCcr, r, f);	// mdlCcr already holds prior ops
		opValid <= valid;
		ccrLoad <= load;
		op <= o;
		isByte <= b;
		srcOp <= s;
		dstOp <= d;
		ccrIn <= ldVal;
		if (valid) mdlOut <= r;
		if (load) mdlCcr <= ldVal;	// Load beats op for the CCR
		else if (valid) mdlCcr <= f;
	endtask

	// DUT shows a strobed result one edge after capture
	always @(posedge clk) begin
		expOut <= mdlOut;
		expCcr <= mdlCcr;
	end

	aluOutMatch: assert property (@(posedge clk) disable iff (!arstN) aluOut == expOut)
		else failValue("aluOut", $sampled(expOut), $sampled(aluOut));
	ccrMatch: assert property (@(posedge clk) disable iff (!arstN) ccr == expCcr)
		else failValue("ccr", {11'd0, $sampled(expCcr)}, {11'd0, $sampled(ccr)});
	zeMatch: assert property (@(posedge clk) disable iff (!arstN) ze == ~expCcr.z)
		else failValue("ze", {15'd0, ~$sampled(expCcr.z)}, {15'd0, $sampled(ze)});

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			abortRun("Timeout: stimulus did not finish within the cycle limit");
		end
	end

	initial begin
		arstN <= 1'b0;
		opValid <= 1'b0;
		op <= aluPkg::opAnd;
		isByte <= 1'b0;
		srcOp <= '0;
		dstOp <= '0;
		ccrLoad <= 1'b0;
		ccrIn <= '0;
		mdlOut <= '0;
		mdlCcr <= '0;
		cycles <= 0;
		repeat (5) @(posedge clk);
		arstN <= 1'b1;
		@(posedge clk);
		// Cleared outputs before the first strobe
		assert (aluOut == '0) else failValue("aluOut", '0, aluOut);
		assert (ccr == 5'h00) else failValue("ccr", '0, {11'd0, ccr});
		assert (ze) else failValue("ze", 16'h0001, {15'd0, ze});

		// Every op at both sizes with a random start CCR per block
		for (int k = 0; k < numOps; k++) begin
			for (int sz = 0; sz < 2; sz++) begin
				applyCycle(1'b0, 1'b1, aluPkg::opAnd, 1'b0, '0, '0, randCcr());
				for (int n = 0; n < opsPerCase; n++) begin
					applyCycle(1'b1, 1'b0, aluPkg::aluOp_t'(5'(k)), sz[0], randWord(),
						randWord(), '0);
				end
			end
		end

		// Sticky Z through ADDX/SUBX chains
		applyCycle(1'b0, 1'b1, aluPkg::opAnd, 1'b0, '0, '0, aluPkg::ccr_t'(5'b00100));
		applyCycle(1'b1, 1'b0, aluPkg::opAddx, 1'b0, 16'h0001, 16'h0002, '0);	// Clears Z
		applyCycle(1'b1, 1'b0, aluPkg::opSubx, 1'b0, 16'h0005, 16'h0005, '0);	// Z stays clear
		applyCycle(1'b0, 1'b1, aluPkg::opAnd, 1'b0, '0, '0, aluPkg::ccr_t'(5'b00100));
		applyCycle(1'b1, 1'b0, aluPkg::opAddx, 1'b1, 16'h0000, 16'h0000, '0);
		applyCycle(1'b1, 1'b0, aluPkg::opSubx, 1'b1, 16'h1200, 16'h3400, '0);	// Low bytes zero

		// Direct CCR load alone and together with an op
		applyCycle(1'b0, 1'b1, aluPkg::opAnd, 1'b0, '0, '0, aluPkg::ccr_t'(5'b10101));
		// Loaded flags differ from both the ADD flags and the held CCR
		applyCycle(1'b1, 1'b1, aluPkg::opAdd, 1'b0, 16'h7fff, 16'h0001,
			aluPkg::ccr_t'(5'b10100));

		// Outputs hold through idle cycles with busy inputs
		repeat (4) applyCycle(1'b0, 1'b0, aluPkg::opSub, 1'b1, 16'hffff, 16'h1234, '0);
		repeat (3) applyCycle(1'b0, 1'b0, aluPkg::opAnd, 1'b0, '0, '0, '0);	// Drain checks
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/aluTop.sv
/*
 16-bit ALU top level
 Ties the core, adder, shifter and CCR together
*/
`timescale 1ns/1ps
`default_nettype none

module aluTop (
	input  wire logic                     clk,
	input  wire logic                     arstN,
	input  wire logic                     opValid,
	input  wire aluPkg::aluOp_t           op,
	input  wire logic                     isByte,
	input  wire logic [aluPkg::dataW-1:0] srcOp,
	input  wire logic [aluPkg::dataW-1:0] dstOp,
	input  wire logic                     ccrLoad,
	input  wire aluPkg::ccr_t             ccrIn,
	output logic      [aluPkg::dataW-1:0] aluOut,
	output aluPkg::ccr_t                  ccr,
	output logic                          ze
);

	logic [aluPkg::dataW-1:0] addB, sum, shifted;
	logic addCin, doAdd, cout, ov;
	logic shiftRight, fill, outBit;
	aluPkg::flagSrc_t flagSrc;

	// NOT subtracts from zero instead of dstOp
	assign addB = (op == aluPkg::opNot) ? '0 : dstOp;

	aluCore i_aluCore (
		.clk, .arstN, .opValid, .op, .isByte, .srcOp, .dstOp,
		.ccrCur(ccr), .sum, .cout, .ov, .shifted, .outBit,
		.addCin, .doAdd, .shiftRight, .fill, .flagSrc, .aluOut
	);

	aluAdder i_aluAdder (
		.a(srcOp), .b(addB), .cin(addCin), .doAdd, .isByte,
		.sum, .cout, .ov
	);

	aluShifter i_aluShifter (
		.data(srcOp), .isByte, .shiftRight, .fill, .shifted, .outBit
	);

	ccrReg i_ccrReg (
		.clk, .arstN, .opValid, .op, .flagSrc, .ccrLoad, .ccrIn, .ccr
	);

	assign ze = ~ccr.z;	// High while Z clear

endmodule

`default_nettype wire

// File: rtl/ccrReg.sv
/*
 Condition-code register
 Applies the per-op write mask and the sticky Z rule,
 with direct load taking priority
*/
`timescale 1ns/1ps
`default_nettype none

module ccrReg (
	input  wire logic             clk,
	input  wire logic             arstN,
	input  wire logic             opValid,
	input  wire aluPkg::aluOp_t   op,
	input  wire aluPkg::flagSrc_t flagSrc,
	input  wire logic             ccrLoad,
	input  wire aluPkg::ccr_t     ccrIn,
	output aluPkg::ccr_t          ccr
);

	// Mask bit order follows ccr_t, x n z v c
	localparam logic [4:0] maskKeepX = 5'b01111;
	localparam logic [4:0] maskAll   = 5'b11111;

	logic [4:0] wrMask;
	aluPkg::ccr_t ccrNext;

	// Write mask from op
	always_comb begin
		case (op)
			aluPkg::opAnd, aluPkg::opOr, aluPkg::opEor, aluPkg::opExt,
			aluPkg::opNot, aluPkg::opRol, aluPkg::opRor:
				wrMask = maskKeepX;	// X untouched
			default:
				wrMask = maskAll;
		endcase
	end

	// Merge candidate and current flags
	always_comb begin
		ccrNext = (flagSrc.flags & wrMask) | (ccr & ~wrMask);
		if (flagSrc.stickyZ) begin
			ccrNext.z = flagSrc.flags.z & ccr.z;	// Only clears, multi-precision zero test
		end
	end

	// Load wins over an op in the same cycle
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ccr <= '0;
		end else if (ccrLoad) begin
			ccr <= ccrIn;
		end else if (opValid) begin
			ccr <= ccrNext;
		end
	end

endmodule

`default_nettype wire

// File: rtl/aluCore.sv
/*
 ALU core
 Decodes the op into adder and shifter controls, selects the result,
 computes candidate flags and registers the result
*/
`timescale 1ns/1ps
`default_nettype none

module aluCore (
	input  wire logic                     clk,
	input  wire logic                     arstN,
	input  wire logic                     opValid,
	input  wire aluPkg::aluOp_t           op,
	input  wire logic                     isByte,
	input  wire logic [aluPkg::dataW-1:0] srcOp,
	input  wire logic [aluPkg::dataW-1:0] dstOp,
	input  wire aluPkg::ccr_t             ccrCur,
	input  wire logic [aluPkg::dataW-1:0] sum,	// From adder
	input  wire logic                     cout,
	input  wire logic                     ov,
	input  wire logic [aluPkg::dataW-1:0] shifted,	// From shifter
	input  wire logic                     outBit,
	output logic                          addCin,
	output logic                          doAdd,
	output logic                          shiftRight,
	output logic                          fill,
	output aluPkg::flagSrc_t              flagSrc,
	output logic      [aluPkg::dataW-1:0] aluOut
);

	localparam int W = aluPkg::dataW;

	logic [W-1:0] result;
	logic [W-1:0] logicRes;	// Word-wide logic value before size merge
	logic srcMsb, srcMsbNext;

	assign srcMsb = isByte ? srcOp[7] : srcOp[W-1];
	assign srcMsbNext = isByte ? srcOp[6] : srcOp[W-2];	// Becomes MSB after ASL

	// Adder controls
	always_comb begin
		case (op)
			aluPkg::opAddx, aluPkg::opSubx: addCin = ccrCur.x;
			aluPkg::opNot:                  addCin = 1'b1;	// 0 - src - 1
			default:                        addCin = 1'b0;
		endcase
	end
	assign doAdd = (op == aluPkg::opAdd) || (op == aluPkg::opAddx);

	// Shifter controls
	assign shiftRight = (op == aluPkg::opLsr) || (op == aluPkg::opAsr) ||
	                    (op == aluPkg::opRor) || (op == aluPkg::opRoxr);
	always_comb begin
		case (op)
			aluPkg::opAsr, aluPkg::opRol:   fill = srcMsb;	// Sign keep / rotate in MSB
			aluPkg::opRor:                  fill = srcOp[0];
			aluPkg::opRoxl, aluPkg::opRoxr: fill = ccrCur.x;
			default:                        fill = 1'b0;	// LSL, LSR, ASL
		endcase
	end

	// Result select and candidate flags
	always_comb begin
		logicRes = dstOp & srcOp;
		result = sum;
		flagSrc.flags.x = ccrCur.x;	// Masked off where X is kept
		flagSrc.flags.v = 1'b0;
		flagSrc.flags.c = 1'b0;
		flagSrc.stickyZ = 1'b0;
		case (op)
			aluPkg::opAnd, aluPkg::opOr, aluPkg::opEor: begin
				if (op == aluPkg::opOr) logicRes = dstOp | srcOp;
				else if (op == aluPkg::opEor) logicRes = dstOp ^ srcOp;
				result = isByte ? {dstOp[W-1:8], logicRes[7:0]} : logicRes;	// Upper byte kept
			end
			aluPkg::opExt: result = {{(W-8){srcOp[7]}}, srcOp[7:0]};
			aluPkg::opAdd, aluPkg::opAddx, aluPkg::opSub, aluPkg::opSubx: begin
				flagSrc.flags.x = cout;
				flagSrc.flags.c = cout;
				flagSrc.flags.v = ov;
				flagSrc.stickyZ = (op == aluPkg::opAddx) || (op == aluPkg::opSubx);
			end
			aluPkg::opNot: result = sum;	// C and V stay zero
			default: begin
				// Shifts and rotates
				result = shifted;
				flagSrc.flags.x = outBit;
				flagSrc.flags.c = outBit;
				if (op == aluPkg::opAsl) flagSrc.flags.v = srcMsb ^ srcMsbNext;
			end
		endcase
		flagSrc.flags.n = isByte ? result[7] : result[W-1];
		flagSrc.flags.z = isByte ? ~|result[7:0] : ~|result;
	end

	// Result register, holds without strobe
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			aluOut <= '0;
		end else if (opValid) begin
			aluOut <= result;
		end
	end

endmodule

`default_nettype wire

// File: rtl/aluShifter.sv
/*
 ALU one-bit shifter
 Shifts or rotates one position at byte or word size, inserting a fill bit
 and returning the bit shifted out
*/
`timescale 1ns/1ps
`default_nettype none

module aluShifter (
	input  wire logic [aluPkg::dataW-1:0] data,
	input  wire logic                     isByte,
	input  wire logic                     shiftRight,	// Low is left
	input  wire logic                     fill,	// Bit entering at LSB or size MSB
	output logic      [aluPkg::dataW-1:0] shifted,
	output logic                          outBit
);

	localparam int W = aluPkg::dataW;

	always_comb begin
		if (shiftRight) begin
			if (isByte) begin
				// Upper byte untouched
				shifted = {data[W-1:8], fill, data[7:1]};
			end else begin
				shifted = {fill, data[W-1:1]};
			end
			outBit = data[0];	// LSB leaves on right shift
		end else begin
			if (isByte) begin
				shifted = {data[W-1:8], data[6:0], fill};
				outBit = data[7];	// Byte MSB leaves
			end else begin
				shifted = {data[W-2:0], fill};
				outBit = data[W-1];
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/aluAdder.sv
/*
 ALU adder-subtractor
 Computes b + a + cin or b - a - cin at byte or word size,
 with carry/borrow out and signed overflow
*/
`timescale 1ns/1ps
`default_nettype none

module aluAdder (
	input  wire logic [aluPkg::dataW-1:0] a,	// Source operand
	input  wire logic [aluPkg::dataW-1:0] b,	// Destination operand
	input  wire logic                     cin,
	input  wire logic                     doAdd,	// Low selects subtract
	input  wire logic                     isByte,
	output logic      [aluPkg::dataW-1:0] sum,
	output logic                          cout,
	output logic                          ov
);

	logic [aluPkg::dataW:0] wordRes;	// Extra bit is carry
	logic [8:0] byteRes;
	logic resMsb, dstMsb, srcMsb, srcSign;

	// Both sizes in parallel, size picks afterwards
	always_comb begin
		if (doAdd) begin
			wordRes = {1'b0, b} + {1'b0, a} + {{aluPkg::dataW{1'b0}}, cin};
			byteRes = {1'b0, b[7:0]} + {1'b0, a[7:0]} + {8'h00, cin};
		end else begin
			wordRes = {1'b0, b} - {1'b0, a} - {{aluPkg::dataW{1'b0}}, cin};	// Borrow in top bit
			byteRes = {1'b0, b[7:0]} - {1'b0, a[7:0]} - {8'h00, cin};
		end
	end

	// Byte result sign-extended into upper byte
	assign sum = isByte ? {{(aluPkg::dataW-8){byteRes[7]}}, byteRes[7:0]}
	                    : wordRes[aluPkg::dataW-1:0];
	assign cout = isByte ? byteRes[8] : wordRes[aluPkg::dataW];

	// Sign bits at the chosen size
	assign resMsb = isByte ? byteRes[7] : wordRes[aluPkg::dataW-1];
	assign dstMsb = isByte ? b[7] : b[aluPkg::dataW-1];
	assign srcMsb = isByte ? a[7] : a[aluPkg::dataW-1];
	assign srcSign = doAdd ? srcMsb : ~srcMsb;	// Subtract flips effective sign

	// Same-sign operands giving opposite-sign result
	assign ov = (srcSign & dstMsb & ~resMsb) | (~srcSign & ~dstMsb & resMsb);

endmodule

`default_nettype wire

// File: rtl/aluPkg.sv
/*
 ALU shared definitions
 Word width, operation codes and the condition-code flag layout
*/
`default_nettype none

package aluPkg;

	// Data path width, byte half is fixed at 8 bits
	localparam int dataW = 16;

	// Operation codes. 17 ops, so the code needs 5 bits
	typedef enum logic [4:0] {
		// Logic group
		opAnd,
		opOr,
		opEor,
		opExt,	// Sign-extend low byte
		// Adder group
		opAdd,
		opAddx,	// Add with X as carry in
		opSub,
		opSubx,	// Subtract with X as borrow in
		opNot,	// 0 - src - 1
		// Single-bit shifts and rotates
		opLsl,
		opLsr,
		opAsl,
		opAsr,
		opRol,
		opRor,
		opRoxl,	// Rotate through X
		opRoxr
	} aluOp_t;

	// CCR flags, same bit positions as 68000 SR[4:0]
	typedef struct packed {
		logic x;	// Extend
		logic n;	// Negative
		logic z;	// Zero
		logic v;	// Overflow
		logic c;	// Carry
	} ccr_t;

	// Candidate flags from the core for one operation
	typedef struct packed {
		ccr_t flags;
		logic stickyZ;	// Z may only be cleared, ADDX/SUBX chains
	} flagSrc_t;

endpackage

`default_nettype wire
